// ==== Bender.yml ====
package:
  name: cacheline_adaptor

sources:
  - hw/cacheline_pkg.sv
  - hw/cacheline_adaptor.sv
  - hw/burst_memory.sv
  - hw/cacheline_top.sv
  - target: test
    files:
      - verification/cacheline_sva.sv
      - verification/cacheline_tb.sv

// ==== hw/burst_memory.sv ====
`timescale 1ns/1ps
`default_nettype none

module burst_memory #(
    parameter int unsigned MEM_LINES   = 64,
    parameter int unsigned MEM_LATENCY = 3
) (
    input  logic                  clk,
    input  logic                  reset_n,
    input  cacheline_pkg::addr_t  address_i,
    input  logic                  read_i,
    input  logic                  write_i,
    input  cacheline_pkg::burst_t wdata_i,
    output cacheline_pkg::burst_t rdata_o,
    output logic                  resp_o
);

    import cacheline_pkg::*;

    localparam int unsigned IDX_W = $clog2(MEM_LINES);
    localparam int unsigned LAT_W = $clog2(MEM_LATENCY + 1);

    localparam beat_cnt_t LAST_BEAT = beat_cnt_t'(BEATS - 1);
    localparam logic [LAT_W-1:0] LAT_LAST = LAT_W'(MEM_LATENCY - 1);

    typedef enum logic [1:0] {
        MS_IDLE,
        MS_WAIT,
        MS_BEAT0,
        MS_STREAM
    } mem_state_t;

    mem_state_t       state;
    mem_state_t       state_d;
    logic [LAT_W-1:0] lat_cnt;
    beat_cnt_t        beat_cnt;
    logic [IDX_W-1:0] line_idx;
    logic             beat_en;

    line_t mem [MEM_LINES];

    // upper address bits alias.
    assign line_idx = address_i[LINE_OFFSET_BITS +: IDX_W];

    assign beat_en = (state == MS_BEAT0) || (state == MS_STREAM);

    always_comb begin
        state_d = state;
        case (state)
            MS_IDLE: begin
                if (read_i || write_i) begin
                    if (MEM_LATENCY == 1) begin
                        state_d = MS_BEAT0;
                    end else begin
                        state_d = MS_WAIT;
                    end
                end
            end
            MS_WAIT: begin
                if (lat_cnt == LAT_LAST) begin
                    state_d = MS_BEAT0;
                end
            end
            MS_BEAT0: begin
                state_d = MS_STREAM;
            end
            MS_STREAM: begin
                if (beat_cnt == LAST_BEAT) begin
                    state_d = MS_IDLE;
                end
            end
            default: begin
                state_d = MS_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            state <= MS_IDLE;
            lat_cnt <= '0;
            beat_cnt <= '0;
        end else begin
            state <= state_d;
            case (state)
                MS_IDLE: begin
                    lat_cnt <= LAT_W'(1);  // first strobe cycle counts as one.
                    beat_cnt <= '0;
                end
                MS_WAIT: begin
                    lat_cnt <= lat_cnt + 1'b1;
                end
                MS_BEAT0, MS_STREAM: begin
                    beat_cnt <= beat_cnt + 1'b1;
                end
                default: begin
                    beat_cnt <= '0;
                end
            endcase
        end
    end

    // store one slice per beat.
    always_ff @(posedge clk) begin
        if (beat_en && write_i) begin
            mem[line_idx][beat_cnt*BURST_W +: BURST_W] <= wdata_i;
        end
    end

    assign rdata_o = mem[line_idx][beat_cnt*BURST_W +: BURST_W];
    assign resp_o = (state == MS_BEAT0);  // strobe only with beat 0.

endmodule : burst_memory

`default_nettype wire

// ==== hw/cacheline_adaptor.sv ====
`timescale 1ns/1ps
`default_nettype none

module cacheline_adaptor (
    input  logic                  clk,
    input  logic                  reset_n,

    // line side
    input  cacheline_pkg::line_t  line_i,
    output cacheline_pkg::line_t  line_o,
    input  cacheline_pkg::addr_t  address_i,
    input  logic                  read_i,
    input  logic                  write_i,
    output logic                  resp_o,

    // memory side
    input  cacheline_pkg::burst_t burst_i,
    output cacheline_pkg::burst_t burst_o,
    output cacheline_pkg::addr_t  address_o,
    output logic                  read_o,
    output logic                  write_o,
    input  logic                  resp_i
);

    import cacheline_pkg::*;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_RD_WAIT,
        ST_WR_WAIT,
        ST_RD_STREAM,
        ST_WR_STREAM,
        ST_DONE
    } adaptor_state_t;

    localparam beat_cnt_t LAST_BEAT = beat_cnt_t'(BEATS - 1);

    adaptor_state_t state;
    adaptor_state_t state_d;
    beat_cnt_t      beat_cnt;
    line_t          line_q;
    addr_t          addr_q;

    logic take_rd;
    logic take_wr;
    logic beat_step;
    logic rd_beat;

    assign take_rd = (state == ST_IDLE) && read_i;
    assign take_wr = (state == ST_IDLE) && !read_i && write_i;  // read wins.

    // a beat moves on the bus this cycle.
    assign beat_step = ((state == ST_RD_WAIT || state == ST_WR_WAIT) && resp_i) ||
                       (state == ST_RD_STREAM) || (state == ST_WR_STREAM);

    assign rd_beat = ((state == ST_RD_WAIT) && resp_i) || (state == ST_RD_STREAM);

    always_comb begin
        state_d = state;
        case (state)
            ST_IDLE: begin
                if (take_rd) begin
                    state_d = ST_RD_WAIT;
                end else if (take_wr) begin
                    state_d = ST_WR_WAIT;
                end
            end
            ST_RD_WAIT: begin
                if (resp_i) begin
                    state_d = ST_RD_STREAM;  // beat 0 arrives with resp.
                end
            end
            ST_WR_WAIT: begin
                if (resp_i) begin
                    state_d = ST_WR_STREAM;
                end
            end
            ST_RD_STREAM: begin
                if (beat_cnt == LAST_BEAT) begin
                    state_d = ST_DONE;
                end
            end
            ST_WR_STREAM: begin
                if (beat_cnt == LAST_BEAT) begin
                    state_d = ST_DONE;
                end
            end
            ST_DONE: begin
                state_d = ST_IDLE;
            end
            default: begin
                state_d = ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            state <= ST_IDLE;
            beat_cnt <= '0;
        end else begin
            state <= state_d;
            if (beat_step) begin
                beat_cnt <= beat_cnt + 1'b1;  // wraps to 0 after last beat.
            end else if (state == ST_IDLE) begin
                beat_cnt <= '0;
            end
        end
    end

    // captured request and assembled line.
    always_ff @(posedge clk) begin
        if (take_rd || take_wr) begin
            addr_q <= address_i;
        end
        if (take_wr) begin
            line_q <= line_i;
        end else if (rd_beat) begin
            line_q[beat_cnt*BURST_W +: BURST_W] <= burst_i;  // lowest slice first.
        end
    end

    always_comb begin
        read_o = (state == ST_RD_WAIT) || (state == ST_RD_STREAM);
        write_o = (state == ST_WR_WAIT) || (state == ST_WR_STREAM);
        resp_o = (state == ST_DONE);
    end

    assign burst_o = line_q[beat_cnt*BURST_W +: BURST_W];
    assign address_o = addr_q;
    assign line_o = line_q;  // held until next capture.

endmodule : cacheline_adaptor

`default_nettype wire

// ==== hw/cacheline_pkg.sv ====
`default_nettype none

package cacheline_pkg;

    localparam int unsigned ADDR_W = 32;
    localparam int unsigned BURST_W = 64;
    localparam int unsigned BEATS = 4;
    localparam int unsigned LINE_W = BURST_W * BEATS;

    // line index starts right above these bits.
    localparam int unsigned LINE_OFFSET_BITS = 5;

    typedef logic [ADDR_W-1:0] addr_t;

    typedef logic [BURST_W-1:0] burst_t;

    typedef logic [LINE_W-1:0] line_t;

    typedef logic [$clog2(BEATS)-1:0] beat_cnt_t;

endpackage : cacheline_pkg

`default_nettype wire

// ==== hw/cacheline_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module cacheline_top #(
    parameter int unsigned MEM_LINES   = 64,
    parameter int unsigned MEM_LATENCY = 3
) (
    input  logic                 clk,
    input  logic                 reset_n,
    input  cacheline_pkg::addr_t address_i,
    input  cacheline_pkg::line_t line_i,
    input  logic                 read_i,
    input  logic                 write_i,
    output cacheline_pkg::line_t line_o,
    output logic                 resp_o
);

    import cacheline_pkg::*;

    // memory-side burst bus.
    addr_t  mem_address;
    logic   mem_read;
    logic   mem_write;
    burst_t mem_wdata;
    burst_t mem_rdata;
    logic   mem_resp;

    cacheline_adaptor u_adaptor (
        .clk       (clk),
        .reset_n   (reset_n),
        .line_i    (line_i),
        .line_o    (line_o),
        .address_i (address_i),
        .read_i    (read_i),
        .write_i   (write_i),
        .resp_o    (resp_o),
        .burst_i   (mem_rdata),
        .burst_o   (mem_wdata),
        .address_o (mem_address),
        .read_o    (mem_read),
        .write_o   (mem_write),
        .resp_i    (mem_resp)
    );

    burst_memory #(
        .MEM_LINES   (MEM_LINES),
        .MEM_LATENCY (MEM_LATENCY)
    ) u_memory (
        .clk       (clk),
        .reset_n   (reset_n),
        .address_i (mem_address),
        .read_i    (mem_read),
        .write_i   (mem_write),
        .wdata_i   (mem_wdata),
        .rdata_o   (mem_rdata),
        .resp_o    (mem_resp)
    );

endmodule : cacheline_top

`default_nettype wire

// ==== sim.f ====
hw/cacheline_pkg.sv
hw/cacheline_adaptor.sv
hw/burst_memory.sv
hw/cacheline_top.sv
verification/cacheline_sva.sv
verification/cacheline_tb.sv

// ==== verification/cacheline_sva.sv ====
`timescale 1ns/1ps
`default_nettype none

module cacheline_sva #(
    parameter int unsigned MEM_LATENCY = 3
) (
    input logic clk,
    input logic reset_n,
    input logic read_i,
    input logic write_i,
    input logic resp_o,
    input logic mem_read,
    input logic mem_write,
    input logic mem_resp
);

    import cacheline_pkg::*;

    int unsigned fail_cnt = 0;

    logic adaptor_idle;
    logic capture;

    assign adaptor_idle = !mem_read && !mem_write && !resp_o;  // only idle is silent.
    assign capture = adaptor_idle && (read_i || write_i);

    resp_latency: assert property (@(posedge clk) disable iff (!reset_n)
        capture |-> !resp_o [*(MEM_LATENCY + 5)] ##1 resp_o)
    else begin
        $error("resp_o missing %0d cycles after a captured request", MEM_LATENCY + 5);
        fail_cnt++;
    end

    resp_pulse: assert property (@(posedge clk) disable iff (!reset_n)
        resp_o |=> !resp_o)
    else begin
        $error("resp_o high for more than one cycle");
        fail_cnt++;
    end

    strobe_excl: assert property (@(posedge clk) disable iff (!reset_n)
        !(mem_read && mem_write))
    else begin
        $error("mem_read and mem_write high together");
        fail_cnt++;
    end

    mem_resp_pulse: assert property (@(posedge clk) disable iff (!reset_n)
        mem_resp |=> !mem_resp)
    else begin
        $error("mem_resp high for more than one cycle");
        fail_cnt++;
    end

    // strobe covers exactly the beats.
    burst_len: assert property (@(posedge clk) disable iff (!reset_n)
        mem_resp |-> (mem_read || mem_write) [*BEATS] ##1 !(mem_read || mem_write))
    else begin
        $error("memory strobe does not span exactly %0d beats", BEATS);
        fail_cnt++;
    end

endmodule : cacheline_sva

bind cacheline_top cacheline_sva #(
    .MEM_LATENCY (MEM_LATENCY)
) u_sva (
    .clk       (clk),
    .reset_n   (reset_n),
    .read_i    (read_i),
    .write_i   (write_i),
    .resp_o    (resp_o),
    .mem_read  (mem_read),
    .mem_write (mem_write),
    .mem_resp  (mem_resp)
);

`default_nettype wire

// ==== verification/cacheline_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module cacheline_tb;

    import cacheline_pkg::*;

    localparam int unsigned MEM_LINES = 64;
    localparam int unsigned MEM_LATENCY = 3;
    localparam int unsigned NUM_REQUESTS = 48;
    localparam int unsigned WATCHDOG_CYCLES = NUM_REQUESTS * (MEM_LATENCY + 8) + 100;
    localparam int unsigned RESP_LIMIT = MEM_LATENCY + 20;

    logic  clk;
    logic  reset_n;
    addr_t address_i;
    line_t line_i;
    logic  read_i;
    logic  write_i;
    line_t line_o;
    logic  resp_o;

    line_t       ref_mem [MEM_LINES];  // expected line contents.
    logic        written [MEM_LINES];
    logic [31:0] lcg_state;
    int unsigned errors;
    int unsigned req_count;
    int unsigned resp_count;

    cacheline_top #(
        .MEM_LINES   (MEM_LINES),
        .MEM_LATENCY (MEM_LATENCY)
    ) u_cacheline_top (
        .clk       (clk),
        .reset_n   (reset_n),
        .address_i (address_i),
        .line_i    (line_i),
        .read_i    (read_i),
        .write_i   (write_i),
        .line_o    (line_o),
        .resp_o    (resp_o)
    );

    initial clk = 1'b0;
    always #50 clk = ~clk;

    always @(negedge clk) begin
        if (reset_n && resp_o) begin
            resp_count++;
        end
    end

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic line_t rand_line();
        line_t l;
        for (int i = 0; i < LINE_W / 32; i++) begin
            l[i*32 +: 32] = next_rand();
        end
        return l;
    endfunction

    // line number wraps at the memory depth.
    function automatic int unsigned line_index(input addr_t addr);
        return (addr >> LINE_OFFSET_BITS) % MEM_LINES;
    endfunction

    function automatic int unsigned total_errors();
        return errors + u_cacheline_top.u_sva.fail_cnt;
    endfunction

    task automatic report_test(input int unsigned num, input string name,
                               input int unsigned err_start);
        $display("test %0d %s: %s", num, name, (total_errors() == err_start) ? "ok" : "failed");
    endtask

    task automatic run_request(input logic is_read, input addr_t addr, input line_t wdata,
                               input bit disturb);
        int unsigned cycles;
        bit          got;
        line_t       exp;
        exp = ref_mem[line_index(addr)];
        cycles = 0;
        got = 1'b0;
        @(posedge clk);
        read_i <= is_read;
        write_i <= !is_read;
        address_i <= addr;
        line_i <= wdata;
        req_count++;
        while (!got && cycles < RESP_LIMIT) begin
            @(negedge clk);
            if (resp_o) begin
                got = 1'b1;
            end else begin
                cycles++;
                @(posedge clk);
                if (disturb && cycles > 1) begin
                    address_i <= ~addr;  // ignored while the adaptor is busy.
                    line_i <= rand_line();
                    write_i <= ~write_i;
                end
            end
        end
        if (!got) begin
            $display("no response on resp_o within %0d cycles of a request", RESP_LIMIT);
            errors++;
        end else begin
            assert (cycles == MEM_LATENCY + 5) else begin
                $display("mismatch resp_o latency exp %h got %h", MEM_LATENCY + 5, cycles);
                errors++;
            end
            if (is_read) begin
                assert (line_o === exp) else begin
                    $display("mismatch line_o exp %h got %h", exp, line_o);
                    errors++;
                end
            end
        end
        if (!is_read) begin
            ref_mem[line_index(addr)] = wdata;
            written[line_index(addr)] = 1'b1;
        end
        @(posedge clk);
        read_i <= 1'b0;
        write_i <= 1'b0;
    endtask

    initial begin
        int unsigned err_start;
        int unsigned idx;
        addr_t       addr;
        line_t       data;
        logic [31:0] r;
        lcg_state = 32'hddd7;
        errors = 0;
        req_count = 0;
        resp_count = 0;
        reset_n = 1'b0;
        read_i = 1'b0;
        write_i = 1'b0;
        address_i = '0;
        line_i = '0;
        for (int i = 0; i < MEM_LINES; i++) begin
            ref_mem[i] = '0;
            written[i] = 1'b0;
        end
        repeat (3) @(posedge clk);
        reset_n <= 1'b1;

        err_start = total_errors();
        repeat (6) begin
            @(negedge clk);
            assert (!resp_o && !u_cacheline_top.mem_read && !u_cacheline_top.mem_write) else begin
                $display("response or memory strobe active with no request after reset");
                errors++;
            end
        end
        report_test(1, "reset quiet", err_start);

        err_start = total_errors();
        addr = 32'h0000_0140;
        data = rand_line();
        run_request(1'b0, addr, data, 1'b0);
        run_request(1'b1, addr, '0, 1'b0);
        report_test(2, "write then read", err_start);

        err_start = total_errors();
        addr = 32'h0000_0160;
        run_request(1'b0, addr, rand_line(), 1'b0);
        run_request(1'b1, addr | 32'h0000_001c, '0, 1'b0);  // offset bits do not matter.
        report_test(3, "fixed latency", err_start);

        err_start = total_errors();
        for (int n = 0; n < 40; n++) begin
            idx = (next_rand() >> 16) % 16;
            addr = addr_t'(idx << LINE_OFFSET_BITS) | addr_t'((next_rand() >> 16) % 32);
            r = next_rand();
            if (written[idx] && r[20]) begin
                run_request(1'b1, addr, '0, 1'b0);
            end else begin
                run_request(1'b0, addr, rand_line(), 1'b0);
            end
        end
        report_test(4, "random traffic", err_start);

        err_start = total_errors();
        addr = 32'h0000_0280;
        run_request(1'b0, addr, rand_line(), 1'b1);
        run_request(1'b1, addr, '0, 1'b1);
        repeat (3) @(negedge clk);
        assert (resp_count == req_count) else begin
            $display("mismatch resp_o pulses exp %h got %h", req_count, resp_count);
            errors++;
        end
        report_test(5, "inputs ignored while busy", err_start);

        err_start = total_errors();
        addr = 32'habc0_0000 | 32'h0000_00e0;
        run_request(1'b0, addr, rand_line(), 1'b0);
        run_request(1'b1, 32'h0000_00e0, '0, 1'b0);
        report_test(6, "address aliasing", err_start);

        repeat (4) @(posedge clk);
        $display("requests %0d, responses %0d, errors %0d", req_count, resp_count,
                 total_errors());
        if (total_errors() == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("watchdog expired after %0d cycles, run did not finish", WATCHDOG_CYCLES);
        $display("TESTS FAILED");
        $finish;
    end

endmodule : cacheline_tb

`default_nettype wire
